/* logic/bcfg_pkg.sv */
package bcfg_pkg;

    // register bus widths
    typedef logic [15:0] reg_addr_t;   // quadlet address
    typedef logic [31:0] reg_data_t;   // one quadlet

    // host port opcodes
    typedef enum logic [1:0] {
        OP_READ      = 2'd0,   // single quadlet read
        OP_WRITE     = 2'd1,   // single quadlet write
        OP_BLK_START = 2'd2,   // set block pointer from addr
        OP_BLK_DATA  = 2'd3    // one quadlet into the block buffer
    } host_op_e;

    // request as held by the host while req is high
    typedef struct packed {
        host_op_e  op;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    // bridge to register block, same signal set as the board bus
    typedef struct packed {
        reg_addr_t raddr;       // held for the whole transaction
        reg_addr_t waddr;
        reg_data_t wdata;
        logic      wen;         // quadlet write strobe
        logic      blk_wen;     // block data strobe
        logic      blk_wstart;  // block start strobe
    } reg_bus_t;

    // address map
    localparam reg_addr_t ADDR_STATUS  = 16'h0000;  // id, version, sizes
    localparam reg_addr_t ADDR_IO_DIR  = 16'h0001;  // 1 = pin drives
    localparam reg_addr_t ADDR_IO_OUT  = 16'h0002;  // output levels
    localparam reg_addr_t ADDR_IO_IN   = 16'h0003;  // synchronized inputs, read only
    localparam reg_addr_t ADDR_CHG_CNT = 16'h0004;  // write anything to clear
    localparam reg_addr_t BLK_BASE     = 16'h0100;  // block buffer window

    // firmware version reported in the status word
    localparam logic [7:0] BCFG_VERSION = 8'h21;

endpackage

/* logic/host_bus_bridge.sv */
`timescale 1ns/1ns

module host_bus_bridge (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                req,        // four-phase request
    input  bcfg_pkg::host_req_t host_req,
    output logic                ack,
    output bcfg_pkg::reg_data_t rdata,
    output bcfg_pkg::reg_bus_t  reg_bus,
    input  bcfg_pkg::reg_data_t reg_rdata   // combinational from raddr
);
    import bcfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,      // strobe on the bus
        CAPTURE,   // read data settles
        ACK        // hold ack until req drops
    } state_e;

    state_e    state;
    state_e    state_nxt;
    logic      ack_nxt;
    host_req_t req_q;      // latched request
    logic      op_wen;
    logic      op_blk_wen;
    logic      op_blk_start;

    always_comb begin
        state_nxt = state;
        ack_nxt   = ack;
        case (state)
            IDLE:    if (req) state_nxt = EXEC;
            EXEC:    state_nxt = CAPTURE;
            CAPTURE: state_nxt = ACK;
            ACK: begin
                if (req) begin
                    ack_nxt = 1'b1;   // rises one edge into ACK
                end else begin
                    ack_nxt   = 1'b0;
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_nxt;
            ack   <= ack_nxt;
        end
    end

    // request latch and read data capture
    always_ff @(posedge sysclk) begin
        if (state == IDLE && req)
            req_q <= host_req;      // taken on the edge that leaves IDLE
        if (state == CAPTURE)
            rdata <= reg_rdata;
    end

    // one strobe per op, reads only present the address
    always_comb begin
        op_wen       = 1'b0;
        op_blk_wen   = 1'b0;
        op_blk_start = 1'b0;
        case (req_q.op)
            OP_READ:      ;
            OP_WRITE:     op_wen       = 1'b1;
            OP_BLK_START: op_blk_start = 1'b1;
            OP_BLK_DATA:  op_blk_wen   = 1'b1;
            default:      ;
        endcase
    end

    always_comb begin
        reg_bus.raddr      = req_q.addr;
        reg_bus.waddr      = req_q.addr;    // block start takes offset from here
        reg_bus.wdata      = req_q.wdata;
        reg_bus.wen        = (state == EXEC) && op_wen;
        reg_bus.blk_wen    = (state == EXEC) && op_blk_wen;
        reg_bus.blk_wstart = (state == EXEC) && op_blk_start;
    end

endmodule

/* logic/bcfg_regs.sv */
`timescale 1ns/1ns

module bcfg_regs #(
    parameter int IO_WIDTH  = 16,   // connector pins, 1..32
    parameter int BLK_DEPTH = 8     // block buffer quadlets, power of two
) (
    input  logic                    sysclk,
    input  logic                    arst_n,
    input  logic [3:0]              board_id,   // rotary switch value
    input  bcfg_pkg::reg_bus_t      reg_bus,
    output bcfg_pkg::reg_data_t     reg_rdata,
    output logic [IO_WIDTH-1:0]     io_dir,
    output logic [IO_WIDTH-1:0]     io_out,
    output logic                    chg_clr,
    input  logic [IO_WIDTH-1:0]     io_sync,
    input  logic [15:0]             chg_cnt
);
    import bcfg_pkg::*;

    // at least one pointer bit even for a single entry
    localparam int PTR_W = (BLK_DEPTH > 1) ? $clog2(BLK_DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_MASK = PTR_W'(BLK_DEPTH - 1);

    reg_data_t       blk_mem [BLK_DEPTH];
    logic [PTR_W-1:0] blk_ptr;   // next write slot
    reg_addr_t       wr_off;     // waddr relative to buffer window
    reg_addr_t       rd_off;
    logic            blk_hit;    // raddr inside the window
    logic [PTR_W-1:0] rd_idx;

    assign wr_off = reg_bus.waddr - BLK_BASE;
    assign rd_off = reg_bus.raddr - BLK_BASE;
    assign blk_hit = (reg_bus.raddr >= BLK_BASE) && (rd_off < reg_addr_t'(BLK_DEPTH));
    assign rd_idx = rd_off[PTR_W-1:0] & PTR_MASK;

    // clear strobe straight to the counter, same edge as the write
    assign chg_clr = reg_bus.wen && (reg_bus.waddr == ADDR_CHG_CNT);

    // I/O configuration
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            io_dir <= '0;   // all pins input
            io_out <= '0;
        end else if (reg_bus.wen) begin
            if (reg_bus.waddr == ADDR_IO_DIR)
                io_dir <= reg_bus.wdata[IO_WIDTH-1:0];
            if (reg_bus.waddr == ADDR_IO_OUT)
                io_out <= reg_bus.wdata[IO_WIDTH-1:0];
        end
    end

    // block pointer, wraps at BLK_DEPTH
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            blk_ptr <= '0;
        end else if (reg_bus.blk_wstart) begin
            blk_ptr <= wr_off[PTR_W-1:0] & PTR_MASK;
        end else if (reg_bus.blk_wen) begin
            if (32'(blk_ptr) == BLK_DEPTH - 1)
                blk_ptr <= '0;
            else
                blk_ptr <= blk_ptr + 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reg_bus.blk_wen)
            blk_mem[blk_ptr] <= reg_bus.wdata;
    end

    // read mux, purely from raddr
    always_comb begin
        reg_rdata = '0;
        if (blk_hit) begin
            reg_rdata = blk_mem[rd_idx];
        end else begin
            case (reg_bus.raddr)
                ADDR_STATUS:  reg_rdata = {8'(BLK_DEPTH), 8'(IO_WIDTH),
                                           BCFG_VERSION, 4'h0, board_id};
                ADDR_IO_DIR:  reg_rdata = reg_data_t'(io_dir);
                ADDR_IO_OUT:  reg_rdata = reg_data_t'(io_out);
                ADDR_IO_IN:   reg_rdata = reg_data_t'(io_sync);
                ADDR_CHG_CNT: reg_rdata = reg_data_t'(chg_cnt);
                default:      reg_rdata = '0;   // unmapped
            endcase
        end
    end

endmodule

/* logic/io_port.sv */
`timescale 1ns/1ns

module io_port #(
    parameter int IO_WIDTH = 16
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic [IO_WIDTH-1:0] io_dir,     // 1 = drive the pin
    input  logic [IO_WIDTH-1:0] io_out,
    input  logic                chg_clr,    // one-cycle clear
    output logic [IO_WIDTH-1:0] io_sync,
    output logic [15:0]         chg_cnt,
    output logic [IO_WIDTH-1:0] io_oe,      // to pad wrapper
    output logic [IO_WIDTH-1:0] io_drive,
    input  logic [IO_WIDTH-1:0] io_in       // asynchronous pins
);

    logic [IO_WIDTH-1:0] in_meta;     // first synchronizer stage
    logic [IO_WIDTH-1:0] sync_prev;   // io_sync one cycle back
    logic                in_changed;

    // output path, one register toward the pads
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            io_oe    <= '0;
            io_drive <= '0;
        end else begin
            io_oe    <= io_dir;
            io_drive <= io_out;
        end
    end

    // two-flop synchronizer
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            in_meta   <= '0;
            io_sync   <= '0;
            sync_prev <= '0;
        end else begin
            in_meta   <= io_in;
            io_sync   <= in_meta;
            sync_prev <= io_sync;
        end
    end

    assign in_changed = (io_sync != sync_prev);

    // saturating change counter, clear has priority
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            chg_cnt <= '0;
        else if (chg_clr)
            chg_cnt <= '0;
        else if (in_changed && chg_cnt != 16'hFFFF)
            chg_cnt <= chg_cnt + 16'd1;
    end

endmodule

/* logic/bcfg_top.sv */
`timescale 1ns/1ns

module bcfg_top #(
    parameter int IO_WIDTH  = 16,
    parameter int BLK_DEPTH = 8
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic [3:0]          board_id,
    input  logic                req,
    input  bcfg_pkg::host_req_t host_req,
    output logic                ack,
    output bcfg_pkg::reg_data_t rdata,
    output logic [IO_WIDTH-1:0] io_oe,      // connector, split for simulation
    output logic [IO_WIDTH-1:0] io_drive,
    input  logic [IO_WIDTH-1:0] io_in
);
    import bcfg_pkg::*;

    reg_bus_t            reg_bus;     // bridge to registers
    reg_data_t           reg_rdata;
    logic [IO_WIDTH-1:0] io_dir;
    logic [IO_WIDTH-1:0] io_out;
    logic [IO_WIDTH-1:0] io_sync;
    logic                chg_clr;
    logic [15:0]         chg_cnt;

    host_bus_bridge bridge_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .req       (req),
        .host_req  (host_req),
        .ack       (ack),
        .rdata     (rdata),
        .reg_bus   (reg_bus),
        .reg_rdata (reg_rdata)
    );

    bcfg_regs #(
        .IO_WIDTH  (IO_WIDTH),
        .BLK_DEPTH (BLK_DEPTH)
    ) regs_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .board_id  (board_id),
        .reg_bus   (reg_bus),
        .reg_rdata (reg_rdata),
        .io_dir    (io_dir),
        .io_out    (io_out),
        .chg_clr   (chg_clr),
        .io_sync   (io_sync),
        .chg_cnt   (chg_cnt)
    );

    io_port #(
        .IO_WIDTH (IO_WIDTH)
    ) io_i (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .io_dir   (io_dir),
        .io_out   (io_out),
        .chg_clr  (chg_clr),
        .io_sync  (io_sync),
        .chg_cnt  (chg_cnt),
        .io_oe    (io_oe),
        .io_drive (io_drive),
        .io_in    (io_in)
    );

endmodule

/* verif/bcfg_assert.sv */
`timescale 1ns/1ns

module bcfg_assert (
    input logic               sysclk,
    input logic               arst_n,
    input logic               req,
    input logic               ack,
    input bcfg_pkg::reg_bus_t reg_bus
);

    // ack only comes back for a request that was up on the edge before
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!arst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // one strobe per transaction, never two at once
    one_strobe: assert property (@(posedge sysclk) disable iff (!arst_n)
        $onehot0({reg_bus.wen, reg_bus.blk_wen, reg_bus.blk_wstart}))
        else $error("more than one bus strobe in the same cycle");

    // ack held through the whole request phase
    ack_held: assert property (@(posedge sysclk) disable iff (!arst_n)
        (ack && req) |=> ack)
        else $error("ack dropped before req fell");

endmodule

/* verif/bcfg_tb.sv */
`timescale 1ns/1ns

module bcfg_tb;
    import bcfg_pkg::*;

    localparam int IO_WIDTH  = 16;
    localparam int BLK_DEPTH = 8;
    localparam int N_HS      = 24;   // random reads and writes
    localparam int N_IO      = 16;   // io register writes, each read back
    localparam int N_IN      = 12;   // input values on the connector
    localparam int N_ROUNDS  = 3;    // block rounds
    // start, two bursts of up to 8, window reads and three unmapped reads per round
    localparam int N_TXN = 1 + N_HS + 2 * N_IO + N_IN + 4 + 1 + BLK_DEPTH
                         + N_ROUNDS * (1 + 16 + BLK_DEPTH + 3);
    localparam int MAX_CYCLES = 4 * N_TXN * 12;

    logic                sysclk;
    logic                arst_n;
    logic [3:0]          board_id;
    logic                req;
    host_req_t           host_req;
    logic                ack;
    reg_data_t           rdata;
    logic [IO_WIDTH-1:0] io_oe;
    logic [IO_WIDTH-1:0] io_drive;
    logic [IO_WIDTH-1:0] io_in;

    // reference model
    logic [IO_WIDTH-1:0] dir_m;
    logic [IO_WIDTH-1:0] out_m;
    logic [IO_WIDTH-1:0] in_m;       // last value put on the pins
    reg_data_t           blk_m [BLK_DEPTH];
    int                  ptr_m;
    int                  chg_m;      // differing consecutive inputs
    logic [31:0]         lfsr;
    int                  cycles = 0;

    bcfg_top #(
        .IO_WIDTH  (IO_WIDTH),
        .BLK_DEPTH (BLK_DEPTH)
    ) bcfg_top_i (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .board_id (board_id),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .rdata    (rdata),
        .io_oe    (io_oe),
        .io_drive (io_drive),
        .io_in    (io_in)
    );

    // protocol checks inside the bridge
    bind host_bus_bridge bcfg_assert assert_i (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .req     (req),
        .ack     (ack),
        .reg_bus (reg_bus)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "run stopped on the first error");
    endtask

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_data(input string what, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pins(input string what, input logic [IO_WIDTH-1:0] got,
                              input logic [IO_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t: %s after %0d cycles, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // status word built field by field from the bit layout
    function automatic reg_data_t status_word();
        reg_data_t s;
        s        = '0;
        s[3:0]   = board_id;        // rotary switch
        s[15:8]  = BCFG_VERSION;
        s[23:16] = 8'(IO_WIDTH);    // pin count
        s[31:24] = 8'(BLK_DEPTH);
        return s;
    endfunction

    // expected read data from the address map rules
    function automatic reg_data_t model_read(input reg_addr_t a);
        if (a >= BLK_BASE && (a - BLK_BASE) < 16'(BLK_DEPTH))
            return blk_m[int'(a - BLK_BASE)];
        case (a)
            ADDR_STATUS:  return status_word();
            ADDR_IO_DIR:  return reg_data_t'(dir_m);
            ADDR_IO_OUT:  return reg_data_t'(out_m);
            ADDR_IO_IN:   return reg_data_t'(in_m);
            ADDR_CHG_CNT: return reg_data_t'(chg_m);
            default:      return '0;
        endcase
    endfunction

    // one four-phase transaction, returns once ack is low again
    task automatic host_xfer(input host_op_e op, input reg_addr_t addr,
                             input reg_data_t wdata, output reg_data_t rd);
        int n;
        n = 0;
        @(negedge sysclk);
        host_req.op    = op;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        req            = 1'b1;
        while (!ack) begin
            @(negedge sysclk);
            n++;
        end
        check_cycles("ack rise", n - 1, 3);   // first edge only samples req
        rd  = rdata;
        req = 1'b0;
        n   = 0;
        while (ack) begin
            @(negedge sysclk);
            n++;
        end
        check_cycles("ack fall", n, 1);
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_data_t d);
        reg_data_t rd;
        host_xfer(OP_WRITE, a, d, rd);
        case (a)
            ADDR_IO_DIR:  dir_m = d[IO_WIDTH-1:0];   // masked to the pin count
            ADDR_IO_OUT:  out_m = d[IO_WIDTH-1:0];
            ADDR_CHG_CNT: chg_m = 0;
            default:      ;
        endcase
    endtask

    task automatic read_check(input reg_addr_t a);
        reg_data_t rd;
        host_xfer(OP_READ, a, '0, rd);
        check_data($sformatf("addr %h", a), rd, model_read(a));
    endtask

    task automatic blk_start(input int off);
        reg_data_t rd;
        host_xfer(OP_BLK_START, 16'(BLK_BASE + off), '0, rd);
        ptr_m = off;
    endtask

    task automatic blk_data(input reg_data_t d);
        reg_data_t rd;
        host_xfer(OP_BLK_DATA, BLK_BASE, d, rd);
        blk_m[ptr_m] = d;
        ptr_m = (ptr_m + 1) % BLK_DEPTH;   // wraps like the buffer pointer
    endtask

    initial begin
        reg_addr_t   a;
        logic [31:0] r;
        lfsr     = 32'd94150;
        req      = 1'b0;
        host_req = '0;
        io_in    = '0;
        arst_n   = 1'b0;
        board_id = 4'(rand_bits(4));
        dir_m    = '0;
        out_m    = '0;
        in_m     = '0;
        ptr_m    = 0;
        chg_m    = 0;
        repeat (16) @(negedge sysclk);
        arst_n = 1'b1;
        @(negedge sysclk);

        // reset state and status word
        check_pins("io_oe", io_oe, '0);
        check_pins("io_drive", io_drive, '0);
        read_check(ADDR_STATUS);

        // handshake timing over random ops
        for (int i = 0; i < N_HS; i++) begin
            if (rand_bits(1) == 1)
                read_check(16'(rand_bits(8) % 5));
            else
                reg_write(16'(ADDR_IO_DIR + rand_bits(1)), rand_bits(32));
        end

        // io config writes reach the pins one cycle after ack
        for (int i = 0; i < N_IO; i++) begin
            a = (rand_bits(1) == 1) ? ADDR_IO_OUT : ADDR_IO_DIR;
            reg_write(a, rand_bits(32));
            @(negedge sysclk);
            check_pins("io_oe", io_oe, dir_m);
            check_pins("io_drive", io_drive, out_m);
            read_check(a);
        end

        // input view and change counter
        for (int i = 0; i < N_IN; i++) begin
            r = rand_bits(IO_WIDTH);
            if (r[IO_WIDTH-1:0] != in_m)
                chg_m++;
            in_m  = r[IO_WIDTH-1:0];
            io_in = in_m;
            repeat (6) @(negedge sysclk);   // past sync and count
        end
        read_check(ADDR_IO_IN);
        read_check(ADDR_CHG_CNT);
        reg_write(ADDR_CHG_CNT, rand_bits(32));
        read_check(ADDR_CHG_CNT);

        // block buffer, fill once so every entry is known
        blk_start(0);
        for (int i = 0; i < BLK_DEPTH; i++)
            blk_data(rand_bits(32));
        for (int k = 0; k < N_ROUNDS; k++) begin
            blk_start(int'(rand_bits(8)) % BLK_DEPTH);
            repeat (2) begin
                repeat (int'(rand_bits(3)) + 1)   // burst of 1 to 8
                    blk_data(rand_bits(32));
            end
            for (int i = 0; i < BLK_DEPTH; i++)
                read_check(16'(BLK_BASE + i));
            read_check(16'(BLK_BASE + BLK_DEPTH));       // just past the window
            read_check(16'(16'h0005 + rand_bits(7)));
            read_check(16'(16'h8000 + rand_bits(15)));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* bcfg_top.f */
logic/bcfg_pkg.sv
logic/host_bus_bridge.sv
logic/bcfg_regs.sv
logic/io_port.sv
logic/bcfg_top.sv
verif/bcfg_assert.sv
verif/bcfg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the bcfg testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module bcfg_tb -Mdir obj_dir -f bcfg_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vbcfg_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
